/* src/fxp_pkg.sv */
`default_nettype none

package fxp_pkg;

    // Operation codes carried in CTRL[1:0], code 3 is reserved
    typedef enum logic [1:0] {
        op_mul = 2'd0,
        op_mac = 2'd1,
        op_clr = 2'd2
    } fxp_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_iterate,
        st_done
    } booth_state_t;

    typedef enum logic {
        st_ready,
        st_wait_mul
    } seq_state_t;

    localparam int AXI_ADDR_W = 5;
    localparam int AXI_DATA_W = 32;

    // Register byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_OPA    = 5'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_OPB    = 5'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 5'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 5'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_ACC    = 5'h10;

    // Q8.7 operands by default
    localparam int DEF_WIDTH     = 16;
    localparam int DEF_FRAC_BITS = 7;

endpackage

`default_nettype wire

/* src/booth_multiplier.sv */
`default_nettype none

module booth_multiplier #(
    parameter int WIDTH     = fxp_pkg::DEF_WIDTH,
    parameter int FRAC_BITS = fxp_pkg::DEF_FRAC_BITS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic signed [WIDTH-1:0] multiplicand,
    input  logic signed [WIDTH-1:0] multiplier,
    output logic signed [WIDTH-1:0] product,
    output logic                    overflow,
    output logic                    done
);
    import fxp_pkg::*;

    localparam int CNT_W = $clog2(WIDTH);
    // Result sign bit plus everything above it
    localparam int TOP_W = WIDTH - FRAC_BITS + 1;
    localparam logic [2*WIDTH-1:0] ROUND_HALF = (2*WIDTH)'(1) << (FRAC_BITS - 1);

    booth_state_t state;
    logic [CNT_W-1:0] count;

    // One extra bit so that negating the most negative multiplicand cannot wrap
    logic signed [WIDTH:0] mcand;
    logic signed [WIDTH:0] part_a;
    logic [WIDTH:0] q;
    logic signed [WIDTH:0] addend;
    logic signed [WIDTH:0] sum;

    logic [2*WIDTH-1:0] rounded;
    logic [TOP_W-1:0] top_bits;

    // Booth recoding on the two low bits of Q
    always_comb begin
        case (q[1:0])
            2'b01: addend = mcand;
            2'b10: addend = -mcand;
            default: addend = '0;
        endcase
    end

    assign sum = part_a + addend;

    // Round at half an LSB of the Q format
    assign rounded = {part_a[WIDTH-1:0], q[WIDTH:1]} + ROUND_HALF;
    assign top_bits = rounded[2*WIDTH-1 -: TOP_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_iterate;
                        count <= '0;
                    end
                end
                st_iterate: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(WIDTH - 1)) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            mcand  <= {multiplicand[WIDTH-1], multiplicand};
            part_a <= '0;
            q      <= {multiplier, 1'b0};
        end else if (state == st_iterate) begin
            // Arithmetic shift of A:Q after the add
            part_a <= {sum[WIDTH], sum[WIDTH:1]};
            q      <= {sum[0], q[WIDTH:1]};
        end
        if (state == st_done) begin
            product  <= rounded[FRAC_BITS+WIDTH-1 -: WIDTH];
            overflow <= !((&top_bits) || !(|top_bits));
        end
    end

    // The sequencer must not restart a multiplication in flight
    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> state == st_idle
    );

    // Capture cycle, WIDTH iterations and the done state, then a single pulse
    done_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> ##(WIDTH + 2) done ##1 !done
    );

endmodule

`default_nettype wire

/* src/mac_sequencer.sv */
`default_nettype none

module mac_sequencer #(
    parameter int WIDTH = fxp_pkg::DEF_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  fxp_pkg::fxp_op_t        cmd_op,
    input  logic [WIDTH-1:0]        opa,
    input  logic [WIDTH-1:0]        opb,
    output logic                    busy,
    output logic signed [WIDTH-1:0] acc,
    output logic                    ovf,
    output logic                    mul_start,
    output logic [WIDTH-1:0]        mul_a,
    output logic [WIDTH-1:0]        mul_b,
    input  logic [WIDTH-1:0]        mul_product,
    input  logic                    mul_overflow,
    input  logic                    mul_done
);
    import fxp_pkg::*;

    localparam logic signed [WIDTH-1:0] ACC_MAX = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic signed [WIDTH-1:0] ACC_MIN = {1'b1, {(WIDTH-1){1'b0}}};

    seq_state_t state;
    fxp_op_t op_q;

    logic signed [WIDTH:0] mac_sum;
    logic mac_ovf;
    logic signed [WIDTH-1:0] mac_sat;

    // One guard bit, saturate when it disagrees with the sign
    assign mac_sum = {acc[WIDTH-1], acc} + {mul_product[WIDTH-1], mul_product};
    assign mac_ovf = mac_sum[WIDTH] ^ mac_sum[WIDTH-1];
    assign mac_sat = mac_ovf ? (mac_sum[WIDTH] ? ACC_MIN : ACC_MAX) : mac_sum[WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_ready;
            op_q      <= op_mul;
            busy      <= 1'b0;
            mul_start <= 1'b0;
            acc       <= '0;
            ovf       <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            case (state)
                st_ready: begin
                    if (cmd_valid) begin
                        case (cmd_op)
                            op_mul, op_mac: begin
                                op_q      <= cmd_op;
                                mul_start <= 1'b1;
                                busy      <= 1'b1;
                                state     <= st_wait_mul;
                            end
                            op_clr: begin
                                acc <= '0;
                                ovf <= 1'b0;
                            end
                            // Reserved code does nothing
                            default: begin
                            end
                        endcase
                    end
                end
                st_wait_mul: begin
                    // Commands arriving here are dropped
                    if (mul_done) begin
                        busy  <= 1'b0;
                        state <= st_ready;
                        if (op_q == op_mac) begin
                            acc <= mac_sat;
                            ovf <= ovf | mul_overflow | mac_ovf;
                        end else begin
                            acc <= mul_product;
                            ovf <= ovf | mul_overflow;
                        end
                    end
                end
                default: begin
                    state <= st_ready;
                end
            endcase
        end
    end

    // Operands are frozen for the multiplier when a command starts
    always_ff @(posedge clk) begin
        if (state == st_ready && cmd_valid) begin
            mul_a <= opa;
            mul_b <= opb;
        end
    end

    done_only_when_waiting: assert property (
        @(posedge clk) disable iff (rst)
        mul_done |-> state == st_wait_mul
    );

endmodule

`default_nettype wire

/* src/axi_lite_regs.sv */
`default_nettype none

module axi_lite_regs #(
    parameter int WIDTH = fxp_pkg::DEF_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [fxp_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  logic [fxp_pkg::AXI_DATA_W-1:0]  s_axi_wdata,
    input  logic [fxp_pkg::AXI_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  logic [fxp_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [fxp_pkg::AXI_DATA_W-1:0]  s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    output logic [WIDTH-1:0]                opa,
    output logic [WIDTH-1:0]                opb,
    output logic                            cmd_valid,
    output fxp_pkg::fxp_op_t                cmd_op,
    input  logic                            busy,
    input  logic signed [WIDTH-1:0]         acc,
    input  logic                            ovf
);
    import fxp_pkg::*;

    localparam int EXT_W = AXI_DATA_W - WIDTH;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic wr_fire;
    logic rd_fire;
    logic [AXI_DATA_W-1:0] rd_mux;

    // Full-word writes only, s_axi_wstrb is not looked at
    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    assign wr_fire = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;

    // Write channel
    always_ff @(posedge clk) begin
        if (rst) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            cmd_valid     <= 1'b0;
            opa           <= '0;
            opb           <= '0;
        end else begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            cmd_valid     <= 1'b0;
            // Address and data are taken together, one write at a time
            if (!s_axi_awready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid) begin
                s_axi_awready <= 1'b1;
                s_axi_wready  <= 1'b1;
            end
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                case (s_axi_awaddr)
                    REG_OPA: opa <= s_axi_wdata[WIDTH-1:0];
                    REG_OPB: opb <= s_axi_wdata[WIDTH-1:0];
                    REG_CTRL: cmd_valid <= 1'b1;
                    default: begin
                    end
                endcase
            end else if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && s_axi_awaddr == REG_CTRL) begin
            cmd_op <= fxp_op_t'(s_axi_wdata[1:0]);
        end
    end

    // Read channel
    assign s_axi_arready = !s_axi_rvalid;
    assign rd_fire = s_axi_arvalid && s_axi_arready;

    always_comb begin
        case (s_axi_araddr)
            REG_OPA: rd_mux = {{EXT_W{opa[WIDTH-1]}}, opa};
            REG_OPB: rd_mux = {{EXT_W{opb[WIDTH-1]}}, opb};
            REG_STATUS: rd_mux = {{(AXI_DATA_W-2){1'b0}}, ovf, busy};
            REG_ACC: rd_mux = {{EXT_W{acc[WIDTH-1]}}, acc};
            // CTRL is write-only, holes read zero
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_mux;
        end
    end

    bvalid_held: assert property (
        @(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    );

    rdata_stable: assert property (
        @(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
    );

endmodule

`default_nettype wire

/* src/fxp_mac_top.sv */
`default_nettype none

module fxp_mac_top #(
    parameter int WIDTH     = fxp_pkg::DEF_WIDTH,
    parameter int FRAC_BITS = fxp_pkg::DEF_FRAC_BITS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [fxp_pkg::AXI_ADDR_W-1:0]   s_axi_awaddr,
    input  logic                             s_axi_awvalid,
    output logic                             s_axi_awready,
    input  logic [fxp_pkg::AXI_DATA_W-1:0]   s_axi_wdata,
    input  logic [fxp_pkg::AXI_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                             s_axi_wvalid,
    output logic                             s_axi_wready,
    output logic [1:0]                       s_axi_bresp,
    output logic                             s_axi_bvalid,
    input  logic                             s_axi_bready,
    input  logic [fxp_pkg::AXI_ADDR_W-1:0]   s_axi_araddr,
    input  logic                             s_axi_arvalid,
    output logic                             s_axi_arready,
    output logic [fxp_pkg::AXI_DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]                       s_axi_rresp,
    output logic                             s_axi_rvalid,
    input  logic                             s_axi_rready
);
    import fxp_pkg::*;

    logic [WIDTH-1:0] opa;
    logic [WIDTH-1:0] opb;
    logic cmd_valid;
    fxp_op_t cmd_op;
    logic busy;
    logic signed [WIDTH-1:0] acc;
    logic ovf;

    logic mul_start;
    logic [WIDTH-1:0] mul_a;
    logic [WIDTH-1:0] mul_b;
    logic signed [WIDTH-1:0] mul_product;
    logic mul_overflow;
    logic mul_done;

    axi_lite_regs #(
        .WIDTH(WIDTH)
    ) regs0 (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .opa           (opa),
        .opb           (opb),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .busy          (busy),
        .acc           (acc),
        .ovf           (ovf)
    );

    mac_sequencer #(
        .WIDTH(WIDTH)
    ) seq0 (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .opa          (opa),
        .opb          (opb),
        .busy         (busy),
        .acc          (acc),
        .ovf          (ovf),
        .mul_start    (mul_start),
        .mul_a        (mul_a),
        .mul_b        (mul_b),
        .mul_product  (mul_product),
        .mul_overflow (mul_overflow),
        .mul_done     (mul_done)
    );

    booth_multiplier #(
        .WIDTH     (WIDTH),
        .FRAC_BITS (FRAC_BITS)
    ) mul0 (
        .clk          (clk),
        .rst          (rst),
        .start        (mul_start),
        .multiplicand (mul_a),
        .multiplier   (mul_b),
        .product      (mul_product),
        .overflow     (mul_overflow),
        .done         (mul_done)
    );

endmodule

`default_nettype wire

/* tb/fxp_mac_tb.sv */
`default_nettype none

module fxp_mac_tb;
    import fxp_pkg::*;

    localparam int W = DEF_WIDTH;
    localparam int N_RANDOM = 50;
    localparam int N_MAC = 8;
    // Random pairs each get a clear, plus the directed operations
    localparam int N_OPS = 2 * N_RANDOM + N_MAC + 20;
    localparam int CYCLES_PER_OP = 40;
    localparam int TIMEOUT_CYCLES = N_OPS * CYCLES_PER_OP + 1000;
    localparam int MAX_POLLS = 20;
    localparam int Q_MAX = 2 ** (W - 1) - 1;
    localparam int Q_MIN = -(2 ** (W - 1));

    logic clk = 1'b0;
    logic rst;
    logic [AXI_ADDR_W-1:0] s_axi_awaddr;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [AXI_DATA_W-1:0] s_axi_wdata;
    logic [AXI_DATA_W/8-1:0] s_axi_wstrb;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic [AXI_ADDR_W-1:0] s_axi_araddr;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic [AXI_DATA_W-1:0] s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic s_axi_rvalid;
    logic s_axi_rready;

    logic [31:0] rng_state;
    logic [W-1:0] model_acc;
    logic model_ovf;

    fxp_mac_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    always #10 clk = ~clk;

    // Responses must stay up until the testbench accepts them
    bvalid_holds: assert property (
        @(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    ) else begin
        $display("write response was withdrawn before bready");
        $display("TEST FAILED");
        $fatal(1, "protocol error on the write response");
    end

    rvalid_holds: assert property (
        @(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid
    ) else begin
        $display("read response was withdrawn before rready");
        $display("TEST FAILED");
        $fatal(1, "protocol error on the read response");
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "simulation hung");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Shift down by 0..7 bits so that small products show up too
    function automatic logic [W-1:0] shape_operand(input logic [31:0] r);
        return $signed(r[W-1:0]) >>> r[18:16];
    endfunction

    // Rounded Q product with the overflow flag in the top bit
    function automatic logic [W:0] ref_product(input logic [W-1:0] a, input logic [W-1:0] b);
        longint p;
        longint q;
        p = longint'($signed(a)) * longint'($signed(b)) + (longint'(1) << (DEF_FRAC_BITS - 1));
        q = p >>> DEF_FRAC_BITS;
        return {(q > Q_MAX || q < Q_MIN), q[W-1:0]};
    endfunction

    task automatic apply_model(input fxp_op_t op, input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0] prod;
        int sum;
        prod = ref_product(a, b);
        sum = int'($signed(model_acc)) + int'($signed(prod[W-1:0]));
        case (op)
            op_mul: begin
                model_acc = prod[W-1:0];
                model_ovf = model_ovf | prod[W];
            end
            op_mac: begin
                model_ovf = model_ovf | prod[W] | (sum > Q_MAX) | (sum < Q_MIN);
                if (sum > Q_MAX) begin
                    model_acc = W'(Q_MAX);
                end else if (sum < Q_MIN) begin
                    model_acc = W'(Q_MIN);
                end else begin
                    model_acc = sum[W-1:0];
                end
            end
            op_clr: begin
                model_acc = '0;
                model_ovf = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        s_axi_awaddr <= addr;
        s_axi_wdata <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid <= 1'b1;
        do @(negedge clk); while (!(s_axi_awready && s_axi_wready));
        @(posedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b0;
        do @(negedge clk); while (!s_axi_bvalid);
        check_value("bresp", 32'(s_axi_bresp), 32'h0);
        // Hold bready off for a cycle so the response has to wait
        @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        s_axi_araddr <= addr;
        s_axi_arvalid <= 1'b1;
        do @(negedge clk); while (!s_axi_arready);
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
        do @(negedge clk); while (!s_axi_rvalid);
        data = s_axi_rdata;
        check_value("rresp", 32'(s_axi_rresp), 32'h0);
        @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        s_axi_rready <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls = 0;
        axi_read(REG_STATUS, status);
        while (status[0]) begin
            polls++;
            if (polls > MAX_POLLS) begin
                $display("busy still set after %0d status reads", polls);
                $display("TEST FAILED");
                $fatal(1, "sequencer never went idle");
            end else begin
                axi_read(REG_STATUS, status);
            end
        end
    endtask

    task automatic run_op(input fxp_op_t op);
        axi_write(REG_CTRL, 32'(op));
        wait_idle();
    endtask

    task automatic check_results();
        logic [31:0] data;
        axi_read(REG_ACC, data);
        check_value("ACC", data, {{(32 - W){model_acc[W-1]}}, model_acc});
        axi_read(REG_STATUS, data);
        check_value("STATUS", data, {30'h0, model_ovf, 1'b0});
    endtask

    task automatic exec_and_check(input fxp_op_t op, input logic [W-1:0] a,
                                  input logic [W-1:0] b);
        axi_write(REG_OPA, 32'(a));
        axi_write(REG_OPB, 32'(b));
        run_op(op);
        apply_model(op, a, b);
        check_results();
    endtask

    initial begin
        logic [31:0] data;
        logic [W-1:0] a;
        logic [W-1:0] b;
        rst = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '1;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        rng_state = 32'd59;
        model_acc = '0;
        model_ovf = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Reset state, sign extension and unmapped holes
        axi_read(REG_STATUS, data);
        check_value("STATUS", data, 32'h0);
        axi_read(REG_ACC, data);
        check_value("ACC", data, 32'h0);
        axi_write(REG_OPA, 32'h0000_8123);
        axi_write(REG_OPB, 32'habcd_0456);
        axi_read(REG_OPA, data);
        check_value("OPA", data, 32'hffff_8123);
        axi_read(REG_OPB, data);
        check_value("OPB", data, 32'h0000_0456);
        axi_read(REG_CTRL, data);
        check_value("CTRL", data, 32'h0);
        axi_read(5'h14, data);
        check_value("unmapped 0x14", data, 32'h0);
        axi_read(5'h1c, data);
        check_value("unmapped 0x1c", data, 32'h0);

        // Random multiplies from a clean accumulator
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            a = shape_operand(rng_state);
            rng_state = xorshift32(rng_state);
            b = shape_operand(rng_state);
            exec_and_check(op_clr, '0, '0);
            exec_and_check(op_mul, a, b);
        end

        // 128.0 squared overflows and 1.0 times 2.0 keeps ovf set
        exec_and_check(op_clr, '0, '0);
        exec_and_check(op_mul, 16'h4000, 16'h4000);
        exec_and_check(op_mul, 16'h0080, 16'h0100);
        exec_and_check(op_clr, '0, '0);

        for (int i = 0; i < N_MAC; i++) begin
            rng_state = xorshift32(rng_state);
            a = shape_operand(rng_state);
            rng_state = xorshift32(rng_state);
            b = shape_operand(rng_state);
            exec_and_check(op_mac, a, b);
        end

        // Plus and minus 64.0 times 2.0 accumulated until both rails are hit
        exec_and_check(op_clr, '0, '0);
        repeat (3) exec_and_check(op_mac, 16'h2000, 16'h0100);
        exec_and_check(op_clr, '0, '0);
        repeat (3) exec_and_check(op_mac, 16'he000, 16'h0100);

        // Second command lands while the first multiply runs
        exec_and_check(op_clr, '0, '0);
        axi_write(REG_OPA, 32'h0000_0180);
        axi_write(REG_OPB, 32'h0000_ff00);
        axi_write(REG_CTRL, 32'(op_mul));
        axi_read(REG_STATUS, data);
        check_value("STATUS.busy", 32'(data[0]), 32'h1);
        axi_write(REG_OPA, 32'h0000_0080);
        axi_write(REG_CTRL, 32'(op_mac));
        wait_idle();
        apply_model(op_mul, 16'h0180, 16'hff00);
        check_results();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* fxp_mac_top.f */
src/fxp_pkg.sv
src/booth_multiplier.sv
src/mac_sequencer.sv
src/axi_lite_regs.sv
src/fxp_mac_top.sv
tb/fxp_mac_tb.sv
